// File: source/knight_pkg.sv
package knight_pkg;

  ////////////////////
  // Word types
  ////////////////////

  // A host command is two UART bytes, the high byte first.
  // The opcode sits in the top nibble.
  typedef logic [15:0] cmd_t;

  // Every command is answered with exactly one byte.
  typedef logic [7:0] resp_t;

  // Board coordinates and knight-move indices both fit in three bits.
  typedef logic [2:0] coord_t;
  typedef logic [2:0] move_t;

  typedef logic [3:0] opcode_t;

  ////////////////////
  // Opcodes
  ////////////////////

  localparam opcode_t OP_CAL   = 4'h2;
  localparam opcode_t OP_SET   = 4'h4;
  localparam opcode_t OP_MOVE  = 4'h6;
  localparam opcode_t OP_QUERY = 4'h8;

  ////////////////////
  // Response codes
  ////////////////////

  // Positive acknowledge for calibration and set position.
  localparam resp_t RESP_ACK  = 8'hA5;
  // Sent when a knight move has been carried out.
  localparam resp_t RESP_MOVE = 8'h5A;
  // Refusal of any kind.
  localparam resp_t RESP_NAK  = 8'hEE;

endpackage

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import knight_pkg::*; #(
  parameter int BAUD_DIV = 16
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  rx,
  output resp_t rx_data,
  output logic  rx_rdy
);

  localparam int CNT_W = $clog2(BAUD_DIV);

  logic             rx_meta;
  logic             rx_sync;
  logic             rx_prev;
  logic             busy;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;
  logic [7:0]       shift;

  // The serial line is asynchronous to clk, so it passes two flops first.
  // A third flop keeps the previous value for start-edge detection.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  // After the falling start edge the counter first runs half a bit time.
  // Every later sample is a whole bit time on, which lands mid-bit.
  // Ten samples are taken, start bit, eight data bits and the stop bit.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      rx_rdy   <= 1'b0;
    end else begin
      rx_rdy <= 1'b0;
      if (!busy) begin
        if (rx_prev && !rx_sync) begin
          busy     <= 1'b1;
          baud_cnt <= CNT_W'(BAUD_DIV / 2 - 1);
          bit_cnt  <= '0;
        end
      end else if (baud_cnt == '0) begin
        baud_cnt <= CNT_W'(BAUD_DIV - 1);
        if (bit_cnt == 4'd9) begin
          busy   <= 1'b0;
          rx_rdy <= 1'b1;
        end else begin
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else begin
        baud_cnt <= baud_cnt - 1'b1;
      end
    end
  end

  // Bits arrive LSB first and shift in from the top.
  // The start-bit sample is passed over, so the eight data samples fill the register.
  // At the stop-bit sample the whole byte is in place.
  always_ff @(posedge clk) begin
    if (busy && (baud_cnt == '0)) begin
      if (bit_cnt == 4'd9) begin
        rx_data <= shift;
      end else if (bit_cnt != 4'd0) begin
        shift <= {rx_sync, shift[7:1]};
      end
    end
  end

endmodule

// File: source/uart_tx.sv
`timescale 1ns/1ps

module uart_tx import knight_pkg::*; #(
  parameter int BAUD_DIV = 16
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  trmt,
  input  resp_t tx_data,
  output logic  tx,
  output logic  tx_done
);

  localparam int CNT_W = $clog2(BAUD_DIV);

  logic [9:0]       shift;
  logic             busy;
  logic [CNT_W-1:0] baud_cnt;
  logic [3:0]       bit_cnt;

  // The line always shows the low end of the frame register.
  assign tx = shift[0];

  // A trigger loads stop, data and start bits into one 10-bit frame.
  // Ones are shifted in behind it, so the line rests high after the stop bit.
  // A trigger that comes while a frame is still going out is ignored.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      shift    <= '1;
      busy     <= 1'b0;
      baud_cnt <= '0;
      bit_cnt  <= '0;
      tx_done  <= 1'b0;
    end else begin
      tx_done <= 1'b0;
      if (!busy) begin
        if (trmt) begin
          shift    <= {1'b1, tx_data, 1'b0};
          busy     <= 1'b1;
          baud_cnt <= CNT_W'(BAUD_DIV - 1);
          bit_cnt  <= '0;
        end
      end else if (baud_cnt == '0) begin
        baud_cnt <= CNT_W'(BAUD_DIV - 1);
        // Bit nine is the stop bit, and the frame ends when its time is up.
        if (bit_cnt == 4'd9) begin
          busy    <= 1'b0;
          tx_done <= 1'b1;
        end else begin
          shift   <= {1'b1, shift[9:1]};
          bit_cnt <= bit_cnt + 4'd1;
        end
      end else begin
        baud_cnt <= baud_cnt - 1'b1;
      end
    end
  end

endmodule

// File: source/uart_cmd_link.sv
`timescale 1ns/1ps

module uart_cmd_link import knight_pkg::*; #(
  parameter int BAUD_DIV = 16
) (
  input  logic  clk,
  input  logic  arst_n,
  input  logic  rx,
  output logic  tx,
  output cmd_t  cmd,
  output logic  cmd_rdy,
  input  logic  send_resp,
  input  resp_t resp
);

  typedef enum logic {HIGH_BYTE, LOW_BYTE} link_state_t;

  link_state_t state;
  resp_t       rx_data;
  resp_t       high_byte;
  resp_t       tx_byte;
  logic        rx_rdy;
  logic        trmt;
  logic        tx_done;
  logic        tx_busy;

  uart_rx #(.BAUD_DIV(BAUD_DIV)) i_rx (
    .clk    (clk),
    .arst_n (arst_n),
    .rx     (rx),
    .rx_data(rx_data),
    .rx_rdy (rx_rdy)
  );

  uart_tx #(.BAUD_DIV(BAUD_DIV)) i_tx (
    .clk    (clk),
    .arst_n (arst_n),
    .trmt   (trmt),
    .tx_data(tx_byte),
    .tx     (tx),
    .tx_done(tx_done)
  );

  // The state says which half of the command the next byte fills.
  // cmd_rdy is registered, so it comes one cycle after the second rx_rdy.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state   <= HIGH_BYTE;
      cmd_rdy <= 1'b0;
    end else begin
      cmd_rdy <= 1'b0;
      if (rx_rdy) begin
        case (state)
          HIGH_BYTE: state <= LOW_BYTE;
          LOW_BYTE: begin
            state   <= HIGH_BYTE;
            cmd_rdy <= 1'b1;
          end
          default: state <= HIGH_BYTE;
        endcase
      end
    end
  end

  // The first byte is kept as the high half and joined with the second one.
  // The finished command appears in the same cycle as cmd_rdy.
  always_ff @(posedge clk) begin
    if (rx_rdy && (state == HIGH_BYTE)) begin
      high_byte <= rx_data;
    end
    if (rx_rdy && (state == LOW_BYTE)) begin
      cmd <= {high_byte, rx_data};
    end
  end

  // The response byte is latched and the transmitter started a cycle later.
  // While a frame is in flight a new send_resp has no effect.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      trmt    <= 1'b0;
      tx_busy <= 1'b0;
    end else begin
      trmt <= send_resp && !tx_busy;
      if (send_resp && !tx_busy) begin
        tx_busy <= 1'b1;
      end else if (tx_done) begin
        tx_busy <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (send_resp && !tx_busy) begin
      tx_byte <= resp;
    end
  end

endmodule

// File: source/cmd_proc.sv
`timescale 1ns/1ps

module cmd_proc import knight_pkg::*; #(
  parameter int CAL_CYCLES = 200,
  parameter int BOARD_SIZE = 5
) (
  input  logic   clk,
  input  logic   arst_n,
  input  cmd_t   cmd,
  input  logic   cmd_rdy,
  output logic   send_resp,
  output resp_t  resp,
  output logic   set_pos,
  output coord_t new_x,
  output coord_t new_y,
  output logic   do_move,
  output move_t  move_idx,
  input  coord_t x,
  input  coord_t y,
  input  logic   move_ok
);

  typedef enum logic [1:0] {IDLE, CAL_WAIT, RESPOND} proc_state_t;

  localparam int CAL_W = $clog2(CAL_CYCLES + 1);

  proc_state_t      state;
  opcode_t          opcode;
  logic             calibrated;
  logic [CAL_W-1:0] cal_cnt;
  logic             set_ok;

  ////////////////////
  // Command fields
  ////////////////////

  // The link holds cmd steady until the next command, so the fields are
  // taken straight from it.
  // Set position and move share the low three bits.
  assign opcode   = cmd[15:12];
  assign new_x    = cmd[6:4];
  assign new_y    = cmd[2:0];
  assign move_idx = cmd[2:0];

  // A requested square must lie on the board in both directions.
  assign set_ok = (int'(new_x) < BOARD_SIZE) && (int'(new_y) < BOARD_SIZE);

  // The answer goes out for the single cycle spent in RESPOND.
  assign send_resp = (state == RESPOND);

  ////////////////////
  // Control FSM
  ////////////////////

  // Every command except calibrate is decided in the cycle of cmd_rdy.
  // The next cycle is RESPOND, where send_resp, set_pos and do_move all show.
  // Calibrate waits CAL_CYCLES in CAL_WAIT before it reaches RESPOND.
  // A command that arrives outside IDLE is dropped without an answer.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state      <= IDLE;
      calibrated <= 1'b0;
      cal_cnt    <= '0;
      set_pos    <= 1'b0;
      do_move    <= 1'b0;
      resp       <= RESP_NAK;
    end else begin
      set_pos <= 1'b0;
      do_move <= 1'b0;
      case (state)
        IDLE: begin
          if (cmd_rdy) begin
            if (opcode == OP_CAL) begin
              state   <= CAL_WAIT;
              cal_cnt <= '0;
            end else begin
              state <= RESPOND;
              resp  <= RESP_NAK;
              // Nothing but calibrate is served before calibration is done.
              if (calibrated) begin
                case (opcode)
                  OP_SET: begin
                    if (set_ok) begin
                      set_pos <= 1'b1;
                      resp    <= RESP_ACK;
                    end
                  end
                  OP_MOVE: begin
                    // move_ok is already judged against the current square.
                    if (move_ok) begin
                      do_move <= 1'b1;
                      resp    <= RESP_MOVE;
                    end
                  end
                  OP_QUERY: resp <= {1'b0, x, 1'b0, y};
                  default:  resp <= RESP_NAK;
                endcase
              end
            end
          end
        end
        CAL_WAIT: begin
          // The calibrated flag stays set until the next reset.
          if (cal_cnt == CAL_W'(CAL_CYCLES - 1)) begin
            calibrated <= 1'b1;
            resp       <= RESP_ACK;
            state      <= RESPOND;
          end else begin
            cal_cnt <= cal_cnt + 1'b1;
          end
        end
        RESPOND: state <= IDLE;
        default: state <= IDLE;
      endcase
    end
  end

endmodule

// File: source/knight_pos.sv
`timescale 1ns/1ps

module knight_pos import knight_pkg::*; #(
  parameter int BOARD_SIZE = 5
) (
  input  logic   clk,
  input  logic   arst_n,
  input  logic   set_pos,
  input  coord_t new_x,
  input  coord_t new_y,
  input  logic   do_move,
  input  move_t  move_idx,
  output coord_t x,
  output coord_t y,
  output logic   move_ok
);

  logic signed [3:0] dx;
  logic signed [3:0] dy;
  logic signed [3:0] tgt_x;
  logic signed [3:0] tgt_y;

  // Moves are numbered clockwise, starting with one right and two up.
  always_comb begin
    case (move_idx)
      3'd0:    begin dx =  4'sd1; dy =  4'sd2; end
      3'd1:    begin dx =  4'sd2; dy =  4'sd1; end
      3'd2:    begin dx =  4'sd2; dy = -4'sd1; end
      3'd3:    begin dx =  4'sd1; dy = -4'sd2; end
      3'd4:    begin dx = -4'sd1; dy = -4'sd2; end
      3'd5:    begin dx = -4'sd2; dy = -4'sd1; end
      3'd6:    begin dx = -4'sd2; dy =  4'sd1; end
      default: begin dx = -4'sd1; dy =  4'sd2; end
    endcase
  end

  // Targets of 8 or 9 wrap to negative values in four bits.
  // They fail the lower bound just as they should fail the upper one.
  assign tgt_x = $signed({1'b0, x}) + dx;
  assign tgt_y = $signed({1'b0, y}) + dy;

  assign move_ok = (tgt_x >= 0) && (tgt_x < BOARD_SIZE) &&
                   (tgt_y >= 0) && (tgt_y < BOARD_SIZE);

  // The knight starts in the corner at (0,0).
  // A move strobe with an off-board target leaves the square as it is.
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      x <= '0;
      y <= '0;
    end else if (set_pos) begin
      x <= new_x;
      y <= new_y;
    end else if (do_move && move_ok) begin
      x <= coord_t'(tgt_x[2:0]);
      y <= coord_t'(tgt_y[2:0]);
    end
  end

endmodule

// File: source/knights_tour.sv
`timescale 1ns/1ps

module knights_tour import knight_pkg::*; #(
  parameter int BAUD_DIV   = 16,
  parameter int CAL_CYCLES = 200,
  parameter int BOARD_SIZE = 5
) (
  input  logic clk,
  input  logic arst_n,
  input  logic rx,
  output logic tx
);

  cmd_t   cmd;
  resp_t  resp;
  coord_t new_x;
  coord_t new_y;
  coord_t x;
  coord_t y;
  move_t  move_idx;
  logic   cmd_rdy;
  logic   send_resp;
  logic   set_pos;
  logic   do_move;
  logic   move_ok;

  // Serial side, turning byte pairs into commands and responses into frames.
  uart_cmd_link #(.BAUD_DIV(BAUD_DIV)) i_link (
    .clk      (clk),
    .arst_n   (arst_n),
    .rx       (rx),
    .tx       (tx),
    .cmd      (cmd),
    .cmd_rdy  (cmd_rdy),
    .send_resp(send_resp),
    .resp     (resp)
  );

  // Command decoding and the calibration wait.
  cmd_proc #(.CAL_CYCLES(CAL_CYCLES), .BOARD_SIZE(BOARD_SIZE)) i_proc (
    .clk      (clk),
    .arst_n   (arst_n),
    .cmd      (cmd),
    .cmd_rdy  (cmd_rdy),
    .send_resp(send_resp),
    .resp     (resp),
    .set_pos  (set_pos),
    .new_x    (new_x),
    .new_y    (new_y),
    .do_move  (do_move),
    .move_idx (move_idx),
    .x        (x),
    .y        (y),
    .move_ok  (move_ok)
  );

  // The position register stands in for the knight on the board
  knight_pos #(.BOARD_SIZE(BOARD_SIZE)) i_pos (
    .clk     (clk),
    .arst_n  (arst_n),
    .set_pos (set_pos),
    .new_x   (new_x),
    .new_y   (new_y),
    .do_move (do_move),
    .move_idx(move_idx),
    .x       (x),
    .y       (y),
    .move_ok (move_ok)
  );

endmodule

// File: dv/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen #(
  parameter int PERIOD = 4
) (
  output logic clk
);

  // The clock starts low, so the first rising edge comes half a period in.
  initial clk = 1'b0;

  always #(PERIOD / 2) clk = ~clk;

endmodule

// File: dv/remote_comm.sv
`timescale 1ns/1ps

module remote_comm #(
  parameter int BAUD_DIV = 16
) (
  input  logic        clk,
  input  logic        arst_n,
  input  logic        snd_cmd,
  input  logic [15:0] cmd,
  output logic        resp_rdy,
  output logic [7:0]  resp,
  output logic        tx,
  input  logic        rx
);

  typedef enum logic [1:0] {HOST_IDLE, SEND_HIGH, SEND_LOW} host_state_t;

  host_state_t state;
  logic [15:0] held_cmd;
  logic [7:0]  tx_byte;
  logic        trmt;
  logic        tx_done;

  // The host side reuses the same serial blocks as the design.
  uart_tx #(.BAUD_DIV(BAUD_DIV)) i_tx (
    .clk    (clk),
    .arst_n (arst_n),
    .trmt   (trmt),
    .tx_data(tx_byte),
    .tx     (tx),
    .tx_done(tx_done)
  );

  // Each response byte from the DUT shows up here with a one-cycle resp_rdy.
  uart_rx #(.BAUD_DIV(BAUD_DIV)) i_rx (
    .clk    (clk),
    .arst_n (arst_n),
    .rx     (rx),
    .rx_data(resp),
    .rx_rdy (resp_rdy)
  );

  // A command goes out as two frames, the high byte first.
  // The second frame is started as soon as the first one reports tx_done.
  // Transmitter inputs change on the falling edge, half a cycle before use.
  always @(negedge clk or negedge arst_n) begin
    if (!arst_n) begin
      state    <= HOST_IDLE;
      held_cmd <= '0;
      tx_byte  <= 8'hFF;
      trmt     <= 1'b0;
    end else begin
      trmt <= 1'b0;
      case (state)
        HOST_IDLE: begin
          if (snd_cmd) begin
            held_cmd <= cmd;
            tx_byte  <= cmd[15:8];
            trmt     <= 1'b1;
            state    <= SEND_HIGH;
          end
        end
        SEND_HIGH: begin
          if (tx_done) begin
            tx_byte <= held_cmd[7:0];
            trmt    <= 1'b1;
            state   <= SEND_LOW;
          end
        end
        SEND_LOW: begin
          if (tx_done) begin
            state <= HOST_IDLE;
          end
        end
        default: state <= HOST_IDLE;
      endcase
    end
  end

endmodule

// File: dv/knights_tour_tb.sv
`timescale 1ns/1ps

module knights_tour_tb;

  localparam int BAUD_DIV    = 16;
  localparam int CAL_CYCLES  = 200;
  localparam int BOARD_SIZE  = 5;
  localparam int N_FIXED     = 18;
  localparam int N_RAND      = 16;
  localparam int N_TESTS     = N_FIXED + 2 * N_RAND;
  localparam int CYCLE_LIMIT = N_TESTS * (CAL_CYCLES + 40 * BAUD_DIV) + 1000;

  localparam logic [7:0] ACK   = 8'hA5;
  localparam logic [7:0] MOVED = 8'h5A;
  localparam logic [7:0] NAK   = 8'hEE;

  logic        clk;
  logic        arst_n;
  logic        rx;
  logic        tx;
  logic        snd_cmd;
  logic [15:0] host_cmd;
  logic [7:0]  resp;
  logic        resp_rdy;

  logic [15:0] cmd_q[$];
  string       label_q[$];
  logic [7:0]  lfsr;
  logic [7:0]  exp_resp;
  logic [7:0]  got_resp;
  logic [2:0]  rand_idx;
  bit          cal_flag;
  int          pos_x;
  int          pos_y;
  int          pass_cnt;
  int          fail_cnt;
  int          cycles = 0;

  tb_clock_gen #(.PERIOD(4)) i_clk (
    .clk(clk)
  );

  knights_tour dut (
    .clk   (clk),
    .arst_n(arst_n),
    .rx    (rx),
    .tx    (tx)
  );

  // The host drives the DUT's rx line and listens on its tx line.
  remote_comm #(.BAUD_DIV(BAUD_DIV)) i_host (
    .clk     (clk),
    .arst_n  (arst_n),
    .snd_cmd (snd_cmd),
    .cmd     (host_cmd),
    .resp_rdy(resp_rdy),
    .resp    (resp),
    .tx      (rx),
    .rx      (tx)
  );

  ////////////////////
  // Reference model
  ////////////////////

  // Knight-move steps, numbered from one right and two up, going clockwise.
  function automatic int step_x(input logic [2:0] idx);
    case (idx)
      3'd0, 3'd3: return 1;
      3'd1, 3'd2: return 2;
      3'd4, 3'd7: return -1;
      default:    return -2;
    endcase
  endfunction

  function automatic int step_y(input logic [2:0] idx);
    case (idx)
      3'd0, 3'd7: return 2;
      3'd1, 3'd6: return 1;
      3'd2, 3'd5: return -1;
      default:    return -2;
    endcase
  endfunction

  // The model tracks the calibrated flag and the square, and gives the expected byte.
  task automatic model_response(input logic [15:0] c, output logic [7:0] exp);
    int         tgt_x;
    int         tgt_y;
    logic [3:0] op;
    op  = c[15:12];
    exp = NAK;
    if (op == 4'h2) begin
      cal_flag = 1'b1;
      exp      = ACK;
    end else if (cal_flag) begin
      case (op)
        4'h4: begin
          tgt_x = c[6:4];
          tgt_y = c[2:0];
          if (tgt_x < BOARD_SIZE && tgt_y < BOARD_SIZE) begin
            pos_x = tgt_x;
            pos_y = tgt_y;
            exp   = ACK;
          end
        end
        4'h6: begin
          tgt_x = pos_x + step_x(c[2:0]);
          tgt_y = pos_y + step_y(c[2:0]);
          if (tgt_x >= 0 && tgt_x < BOARD_SIZE && tgt_y >= 0 && tgt_y < BOARD_SIZE) begin
            pos_x = tgt_x;
            pos_y = tgt_y;
            exp   = MOVED;
          end
        end
        // The query byte is x in the upper nibble and y in the lower one.
        4'h8:    exp = 8'(pos_x * 16 + pos_y);
        default: exp = NAK;
      endcase
    end
  endtask

  ////////////////////
  // Stimulus table
  ////////////////////

  // Fibonacci LFSR over x^8 + x^6 + x^5 + x^4 + 1.
  function automatic logic [7:0] lfsr_next(input logic [7:0] s);
    return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
  endfunction

  // One LFSR step for each of the three index bits.
  task automatic pick_move(output logic [2:0] idx);
    idx = '0;
    repeat (3) begin
      lfsr = lfsr_next(lfsr);
      idx  = {idx[1:0], lfsr[0]};
    end
  endtask

  task automatic add_entry(input logic [15:0] c, input string label);
    cmd_q.push_back(c);
    label_q.push_back(label);
  endtask

  task automatic build_table();
    // Nothing but calibrate is served before calibration.
    add_entry(16'h6000, "move before calibration");
    add_entry(16'h4020, "set before calibration");
    add_entry(16'h8000, "query before calibration");
    add_entry(16'h2000, "calibrate");
    add_entry(16'h8000, "query after calibration");
    add_entry(16'h4020, "set (2,0)");
    add_entry(16'h8000, "query after set");
    add_entry(16'h6007, "move 7 to (1,2)");
    add_entry(16'h8000, "query after move 7");
    add_entry(16'h6004, "move 4 to (0,0)");
    add_entry(16'h8000, "query after move 4");
    add_entry(16'h6004, "move 4 off the board");
    add_entry(16'h8000, "query after refused move");
    add_entry(16'h4050, "set with x of 5");
    add_entry(16'h4027, "set with y of 7");
    add_entry(16'hF000, "unknown opcode");
    add_entry(16'h8000, "query after refusals");
    // The random walk starts from the centre square.
    add_entry(16'h4022, "set (2,2)");
    for (int i = 0; i < N_RAND; i++) begin
      pick_move(rand_idx);
      add_entry({4'h6, 9'b0, rand_idx}, $sformatf("random move %0d", rand_idx));
      add_entry(16'h8000, "query after random move");
    end
  endtask

  // The host picks up the command on the next falling edge and sends both bytes.
  // The response byte is read on the falling edge where resp_rdy is high.
  task automatic send_command(input logic [15:0] c, output logic [7:0] r);
    @(negedge clk);
    host_cmd <= c;
    snd_cmd  <= 1'b1;
    @(negedge clk);
    snd_cmd <= 1'b0;
    @(negedge clk);
    while (!resp_rdy) begin
      @(negedge clk);
    end
    r = resp;
  endtask

  ////////////////////
  // Run control
  ////////////////////

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("The run timed out after %0d cycles before all commands were answered.",
               cycles);
      $display("Test failed");
      $finish;
    end
  end

  initial begin
    arst_n   = 1'b1;
    snd_cmd  = 1'b0;
    host_cmd = '0;
    lfsr     = 8'd64;
    cal_flag = 1'b0;
    pos_x    = 0;
    pos_y    = 0;
    pass_cnt = 0;
    fail_cnt = 0;
    build_table();

    // Reset is held over three rising edges and released on a falling edge.
    #1 arst_n = 1'b0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n <= 1'b1;

    for (int i = 0; i < cmd_q.size(); i++) begin
      model_response(cmd_q[i], exp_resp);
      send_command(cmd_q[i], got_resp);
      assert (got_resp === exp_resp) begin
        pass_cnt++;
      end else begin
        $display("error at %0t ns: %s returned %h, expected %h",
                 $time, label_q[i], got_resp, exp_resp);
        fail_cnt++;
      end
      $display("test %0d %s: cmd %h resp %h expected %h %s", i, label_q[i], cmd_q[i],
               got_resp, exp_resp, (got_resp === exp_resp) ? "ok" : "MISMATCH");
    end

    $display("%0d checks passed, %0d checks failed", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// File: verilog.f
source/knight_pkg.sv
source/uart_rx.sv
source/uart_tx.sv
source/uart_cmd_link.sv
source/cmd_proc.sv
source/knight_pos.sv
source/knights_tour.sv
dv/tb_clock_gen.sv
dv/remote_comm.sv
dv/knights_tour_tb.sv
